//--- list.f
logic/filter_pkg.sv
logic/inversion_filter.sv
logic/brightness_filter.sv
logic/blur_filter.sv
logic/edge_filter.sv
logic/filter_select.sv
logic/video_filter_top.sv
tests/video_filter_tb.sv

//--- logic/blur_filter.sv
module blur_filter import filter_pkg::*; (
	input  logic    clk,
	input  logic    arst_n,

	input  stream_t data_in,
	input  logic    ready_in,

	output logic    ready_out,
	output stream_t data_out
);

	pixel_t  prev_pix;  // Last pixel accepted in this packet
	pixel_t  ref_pix;
	logic    accept;
	stream_t result;

	// Mean of two channels, rounded up
	function automatic logic [3:0] mean_up(input logic [3:0] a, input logic [3:0] b);
		logic [4:0] sum;
		sum = {1'b0, a} + {1'b0, b} + 5'd1;
		return sum[4:1];
	endfunction

	assign ready_out = ready_in | ~data_out.valid;
	assign accept    = data_in.valid & ready_out;

	// A packet start is its own neighbour, so nothing leaks across eop
	assign ref_pix = data_in.sop ? data_in.data : prev_pix;

	always_comb begin
		result        = data_in;
		result.data.r = mean_up(data_in.data.r, ref_pix.r);
		result.data.g = mean_up(data_in.data.g, ref_pix.g);
		result.data.b = mean_up(data_in.data.b, ref_pix.b);
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			prev_pix <= '0;
		end else if (accept) begin
			prev_pix <= data_in.data;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			data_out <= '0;
		end else if (ready_out) begin
			data_out <= result;
		end
	end

endmodule

//--- logic/brightness_filter.sv
module brightness_filter import filter_pkg::*; (
	input  logic       clk,
	input  logic       arst_n,
	input  logic [2:0] freq_flag,  // Brightness lift, 0 to 7

	input  stream_t    data_in,
	input  logic       ready_in,

	output logic       ready_out,
	output stream_t    data_out
);

	stream_t result;

	// Adds the lift to one channel and clips at full scale
	function automatic logic [3:0] lift_ch(input logic [3:0] ch, input logic [2:0] gain);
		logic [4:0] sum;
		sum = {1'b0, ch} + {2'b00, gain};
		if (sum > {1'b0, CHANNEL_MAX}) begin
			return CHANNEL_MAX;
		end
		return sum[3:0];
	endfunction

	assign ready_out = ready_in | ~data_out.valid;

	// freq_flag is taken with the beat it lands on
	always_comb begin
		result        = data_in;
		result.data.r = lift_ch(data_in.data.r, freq_flag);
		result.data.g = lift_ch(data_in.data.g, freq_flag);
		result.data.b = lift_ch(data_in.data.b, freq_flag);
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			data_out <= '0;
		end else if (ready_out) begin
			data_out <= result;
		end
	end

endmodule

//--- logic/edge_filter.sv
module edge_filter import filter_pkg::*; (
	input  logic       clk,
	input  logic       arst_n,
	input  logic [2:0] freq_flag,  // Low two bits give the edge gain

	input  stream_t    data_in,
	input  logic       ready_in,

	output logic       ready_out,
	output stream_t    data_out
);

	pixel_t  prev_pix;
	pixel_t  ref_pix;
	logic    accept;
	stream_t result;

	// Absolute step between neighbours, amplified and clipped
	function automatic logic [3:0] edge_ch(
		input logic [3:0] cur,
		input logic [3:0] prev,
		input logic [1:0] shift
	);
		logic [3:0] diff;
		logic [6:0] scaled;
		diff   = (cur >= prev) ? cur - prev : prev - cur;
		scaled = {3'b000, diff} << shift;
		if (scaled > {3'b000, CHANNEL_MAX}) begin
			return CHANNEL_MAX;
		end
		return scaled[3:0];
	endfunction

	assign ready_out = ready_in | ~data_out.valid;
	assign accept    = data_in.valid & ready_out;
	assign ref_pix   = data_in.sop ? data_in.data : prev_pix;  // First pixel gives zero

	always_comb begin
		result        = data_in;
		result.data.r = edge_ch(data_in.data.r, ref_pix.r, freq_flag[1:0]);
		result.data.g = edge_ch(data_in.data.g, ref_pix.g, freq_flag[1:0]);
		result.data.b = edge_ch(data_in.data.b, ref_pix.b, freq_flag[1:0]);
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			prev_pix <= '0;
		end else if (accept) begin
			prev_pix <= data_in.data;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			data_out <= '0;
		end else if (ready_out) begin
			data_out <= result;
		end
	end

endmodule

//--- logic/filter_pkg.sv
package filter_pkg;

	// Saturation limit of one 4-bit colour channel
	localparam logic [3:0] CHANNEL_MAX = 4'd15;

	// RGB444 pixel, red in the top nibble
	typedef struct packed {
		logic [3:0] r;
		logic [3:0] g;
		logic [3:0] b;
	} pixel_t;

	// One beat of the pixel stream
	typedef struct packed {
		pixel_t data;
		logic   sop;   // First pixel of a packet
		logic   eop;   // Last pixel of a packet
		logic   valid;
	} stream_t;

	// Filter selection, same encoding as the filter_num input
	typedef enum logic [1:0] {
		COLOUR     = 2'b00,  // Inversion
		BLUR       = 2'b01,
		BRIGHTNESS = 2'b10,
		EDGES      = 2'b11
	} filter_sel_e;

endpackage

//--- logic/filter_select.sv
module filter_select import filter_pkg::*; (
	input  logic        clk,
	input  logic        arst_n,
	input  logic [2:0]  freq_flag,
	input  filter_sel_e filter_num,

	input  stream_t     data_in,
	input  logic        ready_in,

	output logic        ready_out,
	output stream_t     data_out
);

	filter_sel_e active_sel;  // Filter owning the current packet
	filter_sel_e sel;
	logic        sop_beat;
	logic        stall;
	stream_t     filt_in  [4];
	stream_t     filt_out [4];
	logic [3:0]  filt_ready_in;
	logic [3:0]  filt_ready_out;

	assign sop_beat = data_in.valid & data_in.sop;

	// Old filter must drain before a different one takes the new packet
	assign stall = sop_beat & (filter_num != active_sel) & data_out.valid;

	// filter_num only counts on a packet start
	assign sel = (sop_beat && !stall) ? filter_num : active_sel;

	assign ready_out = stall ? 1'b0 : filt_ready_out[sel];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			active_sel <= COLOUR;
		end else if (sop_beat && ready_out) begin
			active_sel <= filter_num;
		end
	end

	// Shared input, valid only reaches the selected filter
	always_comb begin
		for (int i = 0; i < 4; i++) begin
			filt_in[i]       = data_in;
			filt_in[i].valid = data_in.valid && !stall && (sel == filter_sel_e'(i));
		end
	end

	always_comb begin
		filt_ready_in      = '0;
		filt_ready_in[sel] = ready_in;  // Others see no ready and hold
	end

	// At most one filter holds a valid beat at any time
	always_comb begin
		data_out = filt_out[active_sel];
		for (int i = 0; i < 4; i++) begin
			if (filt_out[i].valid) begin
				data_out = filt_out[i];
			end
		end
	end

	inversion_filter inv_filt (
		.clk       (clk),
		.arst_n    (arst_n),
		.data_in   (filt_in[COLOUR]),
		.ready_in  (filt_ready_in[COLOUR]),
		.ready_out (filt_ready_out[COLOUR]),
		.data_out  (filt_out[COLOUR])
	);

	blur_filter blur_filt (
		.clk       (clk),
		.arst_n    (arst_n),
		.data_in   (filt_in[BLUR]),
		.ready_in  (filt_ready_in[BLUR]),
		.ready_out (filt_ready_out[BLUR]),
		.data_out  (filt_out[BLUR])
	);

	brightness_filter bright_filt (
		.clk       (clk),
		.arst_n    (arst_n),
		.freq_flag (freq_flag),
		.data_in   (filt_in[BRIGHTNESS]),
		.ready_in  (filt_ready_in[BRIGHTNESS]),
		.ready_out (filt_ready_out[BRIGHTNESS]),
		.data_out  (filt_out[BRIGHTNESS])
	);

	edge_filter edge_filt (
		.clk       (clk),
		.arst_n    (arst_n),
		.freq_flag (freq_flag),
		.data_in   (filt_in[EDGES]),
		.ready_in  (filt_ready_in[EDGES]),
		.ready_out (filt_ready_out[EDGES]),
		.data_out  (filt_out[EDGES])
	);

endmodule

//--- logic/inversion_filter.sv
module inversion_filter import filter_pkg::*; (
	input  logic    clk,
	input  logic    arst_n,

	input  stream_t data_in,
	input  logic    ready_in,   // Back pressure from downstream

	output logic    ready_out,  // Back pressure to upstream
	output stream_t data_out
);

	stream_t result;

	// Register may load when it is empty or draining this cycle
	assign ready_out = ready_in | ~data_out.valid;

	always_comb begin
		result        = data_in;  // sop, eop and valid pass as they are
		result.data.r = CHANNEL_MAX - data_in.data.r;
		result.data.g = CHANNEL_MAX - data_in.data.g;
		result.data.b = CHANNEL_MAX - data_in.data.b;
	end

	// Output stage, holds its beat while stalled
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			data_out <= '0;
		end else if (ready_out) begin
			data_out <= result;  // Empty input loads a bubble
		end
	end

endmodule

//--- logic/video_filter_top.sv
module video_filter_top import filter_pkg::*; (
	input  logic        clk,
	input  logic        arst_n,
	input  logic [2:0]  freq_flag,   // Filter strength
	input  filter_sel_e filter_num,  // Taken at each packet start

	// Pixel stream from upstream
	input  stream_t     data_in,
	output logic        ready_out,

	// Filtered stream to downstream
	output stream_t     data_out,
	input  logic        ready_in
);

	// Later stages hook onto the selector output here
	filter_select u_select (
		.clk        (clk),
		.arst_n     (arst_n),
		.freq_flag  (freq_flag),
		.filter_num (filter_num),
		.data_in    (data_in),
		.ready_in   (ready_in),
		.ready_out  (ready_out),
		.data_out   (data_out)
	);

endmodule

//--- tests/video_filter_tb.sv
module video_filter_tb import filter_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	// Beats sent by all tests together
	localparam int TOTAL_BEATS = 16 + 3 * 8 + 2 * 12 + 2 * 10 + 6 * 10;
	localparam int CYCLE_LIMIT = 4 * TOTAL_BEATS + 200;

	logic        clk = 1'b0;
	logic        arst_n;
	logic [2:0]  freq_flag;
	filter_sel_e filter_num;
	stream_t     data_in;
	logic        ready_in = 1'b1;
	logic        ready_out;
	stream_t     data_out;

	pixel_t  tx_pix [$];   // Pixels of the next packet
	stream_t exp_q [$];    // Expected output beats in order
	int      acc_q [$];    // Cycle each expected beat was accepted
	bit      ready_pat [CYCLE_LIMIT];  // Random ready_in pattern
	int      cycle = 0;
	bit      rand_ready = 1'b0;
	bit      check_latency = 1'b0;
	logic    held = 1'b0;
	stream_t held_beat;
	stream_t got_exp;
	int      got_cyc;

	video_filter_top uut (
		.clk        (clk),
		.arst_n     (arst_n),
		.freq_flag  (freq_flag),
		.filter_num (filter_num),
		.data_in    (data_in),
		.ready_out  (ready_out),
		.data_out   (data_out),
		.ready_in   (ready_in)
	);

	always #10 clk = ~clk;

	always @(negedge clk) begin
		cycle = cycle + 1;
		if (cycle == CYCLE_LIMIT) begin
			$display("Run stopped after %0d cycles with %0d output beats missing",
			         cycle, exp_q.size());
			$display("Simulation failed");
			$fatal(1, "timeout");
		end else if (rand_ready) begin
			ready_in = ready_pat[cycle];
		end else begin
			ready_in = 1'b1;
		end
	end

	task automatic fail_run(input string msg);
		$display("ERROR at %0t: %s", $time, msg);
		$display("Simulation failed");
		$fatal(1, "%s", msg);
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
	                           input logic [31:0] actual);
		if (expected !== actual) begin
			$display("MISMATCH at %0t: %s expected %0h actual %0h", $time, name, expected, actual);
			$display("Simulation failed");
			$fatal(1, "value check");
		end
	endtask

	// Applies the filter rules to each channel
	function automatic pixel_t model_pixel(input filter_sel_e sel, input pixel_t cur,
	                                       input pixel_t prev, input logic [2:0] gain);
		logic [11:0] c_bits;
		logic [11:0] p_bits;
		logic [11:0] res;
		int          c;
		int          p;
		int          v;
		c_bits = cur;
		p_bits = prev;
		for (int k = 0; k < 3; k++) begin
			c = c_bits[k*4 +: 4];
			p = p_bits[k*4 +: 4];
			case (sel)
				COLOUR:     v = 15 - c;
				BRIGHTNESS: v = c + gain;
				BLUR:       v = (c + p + 1) / 2;
				default:    v = (c > p ? c - p : p - c) * (1 << gain[1:0]);
			endcase
			if (v > 15) begin
				v = 15;  // Saturate
			end
			res[k*4 +: 4] = v[3:0];
		end
		return res;
	endfunction

	// Output side sampled on the rising edge
	always @(posedge clk) begin
		if (arst_n) begin
			if (held) begin
				check_value("data_out while stalled", held_beat, data_out);
			end
			if (data_out.valid && ready_in) begin
				if (exp_q.size() == 0) begin
					fail_run("output beat arrived while no beat was expected");
				end else begin
					got_exp = exp_q.pop_front();
					got_cyc = acc_q.pop_front();
					check_value("data_out.data", got_exp.data, data_out.data);
					check_value("data_out.sop", got_exp.sop, data_out.sop);
					check_value("data_out.eop", got_exp.eop, data_out.eop);
					if (check_latency) begin
						check_value("output cycle", got_cyc + 1, cycle);
					end
				end
			end
			held      = data_out.valid & ~ready_in;
			held_beat = data_out;
		end
	end

	task automatic fill_pixels(input int len, input int lo);
		pixel_t p;
		tx_pix.delete();
		for (int i = 0; i < len; i++) begin
			p.r = 4'($urandom_range(15, lo));
			p.g = 4'($urandom_range(15, lo));
			p.b = 4'($urandom_range(15, lo));
			tx_pix.push_back(p);
		end
	endtask

	// Sends tx_pix as one packet and queues the model output per accepted beat
	task automatic send_packet(input filter_sel_e sel, input logic [2:0] gain,
	                           input bit gaps, input bit mid_change);
		stream_t want;
		pixel_t  prev;
		int      len;
		len  = tx_pix.size();
		prev = '0;
		for (int i = 0; i < len; i++) begin
			@(negedge clk);
			while (gaps && $urandom_range(3, 0) == 0) begin
				data_in.valid = 1'b0;
				@(negedge clk);
			end
			data_in.data  = tx_pix[i];
			data_in.sop   = (i == 0);
			data_in.eop   = (i == len - 1);
			data_in.valid = 1'b1;
			freq_flag     = gain;
			filter_num    = (mid_change && i > 0) ? filter_sel_e'(~sel) : sel;
			@(posedge clk);
			while (!ready_out) begin
				@(posedge clk);
			end
			want.data  = model_pixel(sel, tx_pix[i], (i == 0) ? tx_pix[i] : prev, gain);
			want.sop   = (i == 0);
			want.eop   = (i == len - 1);
			want.valid = 1'b1;
			exp_q.push_back(want);
			acc_q.push_back(cycle);
			prev = tx_pix[i];
		end
	endtask

	task automatic end_stream();
		@(negedge clk);
		data_in = '0;
		while (exp_q.size() != 0) begin
			@(negedge clk);
		end
	endtask

	task automatic invert_packet();
		check_latency = 1'b1;
		fill_pixels(16, 0);
		send_packet(COLOUR, 3'd0, 1'b0, 1'b0);
		end_stream();
		check_latency = 1'b0;
	endtask

	task automatic brighten_packets();
		logic [2:0] gains [3] = '{3'd0, 3'd3, 3'd7};
		for (int k = 0; k < 3; k++) begin
			fill_pixels(8, 8);  // Upper half so lifts hit the limit
			send_packet(BRIGHTNESS, gains[k], 1'b0, 1'b0);
		end
		end_stream();
	endtask

	task automatic blur_packets();
		for (int k = 0; k < 2; k++) begin
			fill_pixels(12, 0);
			send_packet(BLUR, 3'd0, 1'b0, 1'b0);
		end
		end_stream();
	endtask

	task automatic edge_packets();
		fill_pixels(10, 0);
		send_packet(EDGES, 3'd0, 1'b0, 1'b0);
		fill_pixels(10, 0);
		send_packet(EDGES, 3'd2, 1'b0, 1'b0);
		end_stream();
	endtask

	// Each packet differs in filter from the one before
	task automatic switch_under_stall();
		rand_ready = 1'b1;
		for (int k = 0; k < 6; k++) begin
			fill_pixels(10, 0);
			send_packet(filter_sel_e'((k * 3) % 4), 3'($urandom_range(7, 0)), 1'b1, k[0]);
		end
		end_stream();
		rand_ready = 1'b0;
	endtask

	initial begin
		void'($urandom(32'hc655_1dfe));
		foreach (ready_pat[i]) begin
			ready_pat[i] = 1'($urandom_range(1, 0));
		end
		arst_n     = 1'b0;
		freq_flag  = '0;
		filter_num = COLOUR;
		data_in    = '0;
		repeat (3) @(negedge clk);
		arst_n = 1'b1;
		check_value("ready_out", 1, ready_out);
		check_value("data_out.valid", 0, data_out.valid);
		invert_packet();
		brighten_packets();
		blur_packets();
		edge_packets();
		switch_under_stall();
		repeat (4) @(negedge clk);
		if (data_out.valid || exp_q.size() != 0) begin
			fail_run("output stream not empty after the last packet");
		end else begin
			$display("Simulation passed");
			$finish;
		end
	end

endmodule
